//--- verification/cluster_stimulus.txt
# grp even hs_delta wire_delta me1a_en me1b_en cluster(hex) valid roll pad size, then expected:
# valid station(1=me1a) wire_lo wire_hi wire_mid xky_lo xky_hi xky_mid xky_win
0 1 0 0 0 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 1 0001 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 1 0002 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 2 1 1 1 0400 1 3 10 2 1 0 17 24 21 12 32 22 10
1 1 2 1 1 1 0801 1 1 0 1 1 0 5 12 9 0 10 1 9
1 1 2 1 1 1 0c02 1 5 100 7 1 0 29 36 33 192 222 207 15
1 1 2 1 1 1 0c03 1 2 3 0 1 0 11 18 15 0 14 6 8
1 1 2 1 1 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 3 2 1 1 1004 1 0 0 0 1 0 0 7 3 498 511 510 12
2 0 3 2 1 1 1005 1 4 1 3 1 0 22 31 27 490 511 505 15
2 0 3 2 1 1 1406 1 6 60 5 1 0 34 43 39 368 402 385 17
2 0 3 2 1 1 1407 1 1 200 4 1 0 4 13 9 90 122 106 16
2 0 3 2 1 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 1 0 1 1 1808 1 7 5 2 1 1 42 47 45 513 523 518 5
3 1 1 0 1 1 1809 1 7 0 3 1 1 42 47 45 512 519 514 5
3 0 1 0 1 1 1c0a 1 7 0 1 1 1 42 47 45 890 895 895 4
3 0 1 0 1 1 1c0b 1 7 40 6 1 1 42 47 45 845 859 852 7
3 0 1 0 1 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
4 1 0 0 0 1 200c 1 7 9 1 1 0 42 47 45 18 20 19 1
4 1 0 0 0 0 200d 1 7 9 1 0 0 0 0 0 0 0 0 0
4 1 0 0 1 0 200e 1 7 2 0 1 1 42 47 45 514 514 514 0
4 1 0 0 1 0 200f 1 3 4 0 0 0 0 0 0 0 0 0 0
4 1 0 0 1 0 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
5 0 0 7 0 1 2410 1 0 50 0 1 0 0 12 3 410 410 410 0
5 0 0 7 0 1 2411 1 1 50 0 1 0 0 18 9 410 410 410 0
5 0 0 7 0 1 2412 1 2 50 0 1 0 5 24 15 410 410 410 0
5 0 0 7 0 1 2413 1 6 50 0 1 0 29 47 39 410 410 410 0
5 0 0 7 0 1 2414 1 7 50 0 1 0 35 47 45 410 410 410 0
5 0 0 7 0 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0
6 1 4 3 1 1 3011 1 2 30 1 1 0 9 20 15 44 78 61 17
6 1 4 3 1 1 3012 1 4 31 2 1 0 21 32 27 46 82 64 18
6 1 4 3 1 1 3013 0 5 90 3 0 0 0 0 0 0 0 0 0
6 1 4 3 1 1 3014 1 7 12 4 1 1 39 47 45 512 544 526 18
6 1 4 3 1 1 3015 0 1 7 0 0 0 0 0 0 0 0 0 0
6 1 4 3 1 1 3016 1 0 8 0 1 0 0 8 3 0 32 16 16
6 1 4 3 1 1 3017 1 6 120 7 1 0 33 44 39 224 270 247 23
6 1 4 3 1 1 0000 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- filelist.f
+incdir+design
design/gem_cluster_pkg.sv
design/csc_coord_pkg.sv
design/lut_stage_if.sv
design/cluster_lut_stage.sv
design/cluster_window_stage.sv
design/cluster_to_csc_top.sv
verification/cluster_to_csc_checker.sv
verification/cluster_to_csc_tb.sv

//--- Makefile
# Verilator build and run for the cluster to csc window pipeline

TOP = cluster_to_csc_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)
	verilator --lint-only -f filelist.f --top-module cluster_to_csc_top

clean:
	rm -rf obj_dir

//--- verification/cluster_to_csc_tb.sv
//**************************************************************************
// testbench top: clock, reset, stimulus file reader, input driver,
// timeout and final report for the cluster to csc window pipeline
//**************************************************************************
`timescale 1ns/100ps
`include "gem_csc_macros.svh"

module cluster_to_csc_tb
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
();

  localparam int MAX_LINES    = 128;
  localparam int COLUMNS      = 20;
  localparam int RESET_CYCLES = 8;
  localparam int SLACK_CYCLES = 20;

  // dut inputs
  logic          logic_clock;
  logic          arst_n;
  logic          even_chamber;
  logic [4:0]    clct_delta_hs;
  logic [2:0]    alct_delta_wire;
  logic          me1a_enable;
  logic          me1b_enable;
  cluster_word_t cluster;
  logic          cluster_valid;
  roll_t         cluster_roll;
  pad_t          cluster_pad;
  size_t         cluster_size;

  // dut outputs
  wire_t         csc_wire_lo;
  wire_t         csc_wire_hi;
  wire_t         csc_wire_mid;
  xky_t          csc_xky_lo;
  xky_t          csc_xky_hi;
  xky_t          csc_xky_mid;
  xky_t          csc_xky_win;
  csc_station_e  csc_station;
  cluster_word_t csc_cluster;
  logic          csc_valid;

  // expected side for the checker
  logic          live;
  int            group_id;
  logic          exp_valid;
  csc_station_e  exp_station;
  wire_t         exp_wire_lo;
  wire_t         exp_wire_hi;
  wire_t         exp_wire_mid;
  xky_t          exp_xky_lo;
  xky_t          exp_xky_hi;
  xky_t          exp_xky_mid;
  xky_t          exp_xky_win;

  int check_count;
  int error_count;
  int test_count;

  // one row per cycle, columns as in the file header
  int stim [MAX_LINES][COLUMNS];
  int n_lines     = 0;
  int load_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  cluster_to_csc_top uut (
    .logic_clock     (logic_clock),
    .arst_n          (arst_n),
    .even_chamber    (even_chamber),
    .clct_delta_hs   (clct_delta_hs),
    .alct_delta_wire (alct_delta_wire),
    .me1a_enable     (me1a_enable),
    .me1b_enable     (me1b_enable),
    .cluster         (cluster),
    .cluster_valid   (cluster_valid),
    .cluster_roll    (cluster_roll),
    .cluster_pad     (cluster_pad),
    .cluster_size    (cluster_size),
    .csc_wire_lo     (csc_wire_lo),
    .csc_wire_hi     (csc_wire_hi),
    .csc_wire_mid    (csc_wire_mid),
    .csc_xky_lo      (csc_xky_lo),
    .csc_xky_hi      (csc_xky_hi),
    .csc_xky_mid     (csc_xky_mid),
    .csc_xky_win     (csc_xky_win),
    .csc_station     (csc_station),
    .csc_cluster     (csc_cluster),
    .csc_valid       (csc_valid)
  );

  cluster_to_csc_checker u_checker (
    .logic_clock  (logic_clock),
    .arst_n       (arst_n),
    .live         (live),
    .group_id     (group_id),
    .exp_cluster  (cluster),
    .exp_valid    (exp_valid),
    .exp_station  (exp_station),
    .exp_wire_lo  (exp_wire_lo),
    .exp_wire_hi  (exp_wire_hi),
    .exp_wire_mid (exp_wire_mid),
    .exp_xky_lo   (exp_xky_lo),
    .exp_xky_hi   (exp_xky_hi),
    .exp_xky_mid  (exp_xky_mid),
    .exp_xky_win  (exp_xky_win),
    .csc_wire_lo  (csc_wire_lo),
    .csc_wire_hi  (csc_wire_hi),
    .csc_wire_mid (csc_wire_mid),
    .csc_xky_lo   (csc_xky_lo),
    .csc_xky_hi   (csc_xky_hi),
    .csc_xky_mid  (csc_xky_mid),
    .csc_xky_win  (csc_xky_win),
    .csc_station  (csc_station),
    .csc_cluster  (csc_cluster),
    .csc_valid    (csc_valid),
    .check_count  (check_count),
    .error_count  (error_count),
    .test_count   (test_count)
  );

  // quiet inputs, nothing handed to the checker
  task automatic drive_idle();
    even_chamber    = 1'b1;
    clct_delta_hs   = '0;
    alct_delta_wire = '0;
    me1a_enable     = 1'b0;
    me1b_enable     = 1'b1;
    cluster         = '0;
    cluster_valid   = 1'b0;
    cluster_roll    = '0;
    cluster_pad     = '0;
    cluster_size    = '0;
    live            = 1'b0;
    group_id        = 0;
    exp_valid       = 1'b0;
    exp_station     = station_me1b;
    exp_wire_lo     = '0;
    exp_wire_hi     = '0;
    exp_wire_mid    = '0;
    exp_xky_lo      = '0;
    exp_xky_hi      = '0;
    exp_xky_mid     = '0;
    exp_xky_win     = '0;
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    int    f [COLUMNS];
    fd = $fopen("verification/cluster_stimulus.txt", "r");
    if (fd == 0) begin
      $display("error: the stimulus file could not be opened");
      load_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // blank lines and column notes
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d %d %d",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
      if (n != COLUMNS) begin
        $display("error: stimulus line with %0d fields instead of %0d", n, COLUMNS);
        load_errors++;
      end else if (n_lines >= MAX_LINES) begin
        $display("error: the stimulus file has more than %0d lines", MAX_LINES);
        load_errors++;
      end else begin
        for (int i = 0; i < COLUMNS; i++) begin
          stim[n_lines][i] = f[i];
        end
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_line(input int i);
    live            = 1'b1;
    group_id        = stim[i][0];
    // configuration
    even_chamber    = 1'(stim[i][1]);
    clct_delta_hs   = 5'(stim[i][2]);
    alct_delta_wire = 3'(stim[i][3]);
    me1a_enable     = 1'(stim[i][4]);
    me1b_enable     = 1'(stim[i][5]);
    // cluster
    cluster         = cluster_word_t'(stim[i][6]);
    cluster_valid   = 1'(stim[i][7]);
    cluster_roll    = roll_t'(stim[i][8]);
    cluster_pad     = pad_t'(stim[i][9]);
    cluster_size    = size_t'(stim[i][10]);
    // expected window
    exp_valid       = 1'(stim[i][11]);
    exp_station     = (stim[i][12] != 0) ? station_me1a : station_me1b;
    exp_wire_lo     = wire_t'(stim[i][13]);
    exp_wire_hi     = wire_t'(stim[i][14]);
    exp_wire_mid    = wire_t'(stim[i][15]);
    exp_xky_lo      = xky_t'(stim[i][16]);
    exp_xky_hi      = xky_t'(stim[i][17]);
    exp_xky_mid     = xky_t'(stim[i][18]);
    exp_xky_win     = xky_t'(stim[i][19]);
  endtask

  // 4 ns clock
  initial begin
    logic_clock = 1'b0;
    forever #2 logic_clock = ~logic_clock;
  end

  // run limit from the stimulus length
  initial begin
    @(posedge logic_clock);
    cycle_limit = n_lines + RESET_CYCLES + SLACK_CYCLES;
    cycle_count = 1;
    while (cycle_count < cycle_limit) begin
      @(posedge logic_clock);
      cycle_count++;
    end
    $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    drive_idle();
    arst_n = 1'b0;
    load_stimulus();
    repeat (RESET_CYCLES) @(posedge logic_clock);
    @(negedge logic_clock);
    arst_n = 1'b1;
    // one line per cycle, changed on the falling edge
    for (int i = 0; i < n_lines; i++) begin
      apply_line(i);
      @(negedge logic_clock);
    end
    drive_idle();
    // drain the pipeline and the checker delay line
    repeat (`PIPE_DEPTH + 2) @(negedge logic_clock);
    $display("tests %0d, checks %0d, errors %0d, stimulus errors %0d",
             test_count, check_count, error_count, load_errors);
    if (load_errors == 0 && error_count == 0 && check_count > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verification/cluster_to_csc_checker.sv
//**************************************************************************
// testbench checker with expected values delayed by the pipeline depth
// compared with the dut outputs at the rising edge
// one report line per test group
//**************************************************************************
`timescale 1ns/100ps
`include "gem_csc_macros.svh"

module cluster_to_csc_checker
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
(
  input  logic          logic_clock,
  input  logic          arst_n,
  // expected values driven with the dut inputs
  input  logic          live,
  input  int            group_id,
  input  cluster_word_t exp_cluster,
  input  logic          exp_valid,
  input  csc_station_e  exp_station,
  input  wire_t         exp_wire_lo,
  input  wire_t         exp_wire_hi,
  input  wire_t         exp_wire_mid,
  input  xky_t          exp_xky_lo,
  input  xky_t          exp_xky_hi,
  input  xky_t          exp_xky_mid,
  input  xky_t          exp_xky_win,
  // dut outputs
  input  wire_t         csc_wire_lo,
  input  wire_t         csc_wire_hi,
  input  wire_t         csc_wire_mid,
  input  xky_t          csc_xky_lo,
  input  xky_t          csc_xky_hi,
  input  xky_t          csc_xky_mid,
  input  xky_t          csc_xky_win,
  input  csc_station_e  csc_station,
  input  cluster_word_t csc_cluster,
  input  logic          csc_valid,
  // running totals
  output int            check_count,
  output int            error_count,
  output int            test_count
);

  localparam int LAST = `PIPE_DEPTH - 1;

  // one expected output word per cycle
  typedef struct packed {
    logic          live;
    int            grp;
    cluster_word_t cluster;
    logic          valid;
    csc_station_e  station;
    wire_t         wire_lo;
    wire_t         wire_hi;
    wire_t         wire_mid;
    xky_t          xky_lo;
    xky_t          xky_hi;
    xky_t          xky_mid;
    xky_t          xky_win;
  } expect_t;

  expect_t exp_now;
  expect_t exp_q [`PIPE_DEPTH];

  int   checks     = 0;
  int   errors     = 0;
  int   tests      = 0;
  int   cur_group  = 0;
  int   grp_checks = 0;
  int   grp_errors = 0;
  logic grp_open   = 1'b0;

  assign check_count = checks;
  assign error_count = errors;
  assign test_count  = tests;

  function automatic string group_name(input int grp);
    case (grp)
      0:       return "reset and idle";
      1:       return "me1b even chamber";
      2:       return "me1b odd chamber";
      3:       return "me1a mapping";
      4:       return "station routing";
      5:       return "wiregroup window";
      6:       return "back-to-back clusters";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    grp_checks++;
    if (expected != actual) begin
      errors++;
      grp_errors++;
      $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic open_group(input int grp);
    cur_group  = grp;
    grp_checks = 0;
    grp_errors = 0;
    grp_open   = 1'b1;
  endtask

  task automatic close_group();
    $display("test %0d %s: %0d checks, %0d errors, %s", cur_group, group_name(cur_group),
             grp_checks, grp_errors, (grp_errors == 0) ? "ok" : "FAILED");
    tests++;
    grp_open = 1'b0;
  endtask

  always_comb begin
    exp_now.live     = live;
    exp_now.grp      = group_id;
    exp_now.cluster  = exp_cluster;
    exp_now.valid    = exp_valid;
    exp_now.station  = exp_station;
    exp_now.wire_lo  = exp_wire_lo;
    exp_now.wire_hi  = exp_wire_hi;
    exp_now.wire_mid = exp_wire_mid;
    exp_now.xky_lo   = exp_xky_lo;
    exp_now.xky_hi   = exp_xky_hi;
    exp_now.xky_mid  = exp_xky_mid;
    exp_now.xky_win  = exp_xky_win;
  end

  // delay line as deep as the dut pipeline
  always @(posedge logic_clock) begin
    if (!arst_n) begin
      for (int i = 0; i < `PIPE_DEPTH; i++) begin
        exp_q[i] <= '0;
      end
    end else begin
      exp_q[0] <= exp_now;
      for (int i = 1; i < `PIPE_DEPTH; i++) begin
        exp_q[i] <= exp_q[i-1];
      end
    end
  end

  // outputs read before this edge updates them
  always @(posedge logic_clock) begin
    if (arst_n && exp_q[LAST].live) begin
      // new group id closes the previous test
      if (grp_open && exp_q[LAST].grp != cur_group) begin
        close_group();
      end
      if (!grp_open) begin
        open_group(exp_q[LAST].grp);
      end
      check_value("csc_valid", int'(exp_q[LAST].valid), int'(csc_valid));
      check_value("csc_cluster", int'(exp_q[LAST].cluster), int'(csc_cluster));
      // window fields only mean something for valid clusters
      if (exp_q[LAST].valid) begin
        check_value("csc_station", int'(exp_q[LAST].station), int'(csc_station));
        check_value("csc_wire_lo", int'(exp_q[LAST].wire_lo), int'(csc_wire_lo));
        check_value("csc_wire_hi", int'(exp_q[LAST].wire_hi), int'(csc_wire_hi));
        check_value("csc_wire_mid", int'(exp_q[LAST].wire_mid), int'(csc_wire_mid));
        check_value("csc_xky_lo", int'(exp_q[LAST].xky_lo), int'(csc_xky_lo));
        check_value("csc_xky_hi", int'(exp_q[LAST].xky_hi), int'(csc_xky_hi));
        check_value("csc_xky_mid", int'(exp_q[LAST].xky_mid), int'(csc_xky_mid));
        check_value("csc_xky_win", int'(exp_q[LAST].xky_win), int'(csc_xky_win));
      end
    end else begin
      // reset and idle slots carry no cluster
      check_value("csc_valid", 0, int'(csc_valid));
      if (grp_open) begin
        close_group();
      end
    end
  end

endmodule

//--- design/cluster_to_csc_top.sv
//**************************************************************************
// top level: gem cluster to csc matching window, two stage pipeline
//**************************************************************************
`timescale 1ns/100ps

module cluster_to_csc_top
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
(
  input  logic          logic_clock,
  input  logic          arst_n,
  // configuration, static while clusters flow
  input  logic          even_chamber,
  input  logic [4:0]    clct_delta_hs,
  input  logic [2:0]    alct_delta_wire,
  input  logic          me1a_enable,
  input  logic          me1b_enable,
  // cluster in
  input  cluster_word_t cluster,
  input  logic          cluster_valid,
  input  roll_t         cluster_roll,
  input  pad_t          cluster_pad,
  input  size_t         cluster_size,
  // matching window out, two cycles later
  output wire_t         csc_wire_lo,
  output wire_t         csc_wire_hi,
  output wire_t         csc_wire_mid,
  output xky_t          csc_xky_lo,
  output xky_t          csc_xky_hi,
  output xky_t          csc_xky_mid,
  output xky_t          csc_xky_win,
  output csc_station_e  csc_station,
  output cluster_word_t csc_cluster,
  output logic          csc_valid
);

  lut_stage_if lut_bus ();

  // stage 1
  cluster_lut_stage u_lut_stage (
    .logic_clock   (logic_clock),
    .arst_n        (arst_n),
    .even_chamber  (even_chamber),
    .me1a_enable   (me1a_enable),
    .me1b_enable   (me1b_enable),
    .cluster       (cluster),
    .cluster_valid (cluster_valid),
    .cluster_roll  (cluster_roll),
    .cluster_pad   (cluster_pad),
    .cluster_size  (cluster_size),
    .lut           (lut_bus.lookup)
  );

  // stage 2
  cluster_window_stage u_window_stage (
    .logic_clock     (logic_clock),
    .arst_n          (arst_n),
    .clct_delta_hs   (clct_delta_hs),
    .alct_delta_wire (alct_delta_wire),
    .lut             (lut_bus.window),
    .csc_wire_lo     (csc_wire_lo),
    .csc_wire_hi     (csc_wire_hi),
    .csc_wire_mid    (csc_wire_mid),
    .csc_xky_lo      (csc_xky_lo),
    .csc_xky_hi      (csc_xky_hi),
    .csc_xky_mid     (csc_xky_mid),
    .csc_xky_win     (csc_xky_win),
    .csc_station     (csc_station),
    .csc_cluster     (csc_cluster),
    .csc_valid       (csc_valid)
  );

endmodule

//--- design/cluster_window_stage.sv
//**************************************************************************
// window stage: pair ordering, delta widening with clamping,
// middle values, strip window width and registered outputs
//**************************************************************************
`timescale 1ns/100ps
`include "gem_csc_macros.svh"

module cluster_window_stage
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
(
  input  logic          logic_clock,
  input  logic          arst_n,
  input  logic [4:0]    clct_delta_hs,
  input  logic [2:0]    alct_delta_wire,
  lut_stage_if.window   lut,
  output wire_t         csc_wire_lo,
  output wire_t         csc_wire_hi,
  output wire_t         csc_wire_mid,
  output xky_t          csc_xky_lo,
  output xky_t          csc_xky_hi,
  output xky_t          csc_xky_mid,
  output xky_t          csc_xky_win,
  output csc_station_e  csc_station,
  output cluster_word_t csc_cluster,
  output logic          csc_valid
);

  xky_t                delta_xky;
  wire_t               delta_wire;
  xky_t                xky_a;
  xky_t                xky_b;
  xky_t                xky_min;
  xky_t                xky_max;
  xky_t                xky_lo;
  xky_t                xky_hi;
  wire_t               wire_lo;
  wire_t               wire_hi;
  logic [`XKY_BITS:0]  xky_hi_sum;
  logic [`WIRE_BITS:0] wire_hi_sum;
  xky_t                xky_lo_win;
  xky_t                xky_hi_win;
  xky_t                xky_mid;
  xky_t                xky_width;
  wire_t               wire_lo_win;
  wire_t               wire_hi_win;
  wire_t               wire_mid;

  // half-strip delta in eighth strips
  assign delta_xky  = xky_t'({clct_delta_hs, 2'b00});
  assign delta_wire = wire_t'(alct_delta_wire);

  // station picks the key pair and its limits
  always_comb begin
    if (lut.station == station_me1a) begin
      xky_a   = lut.xky_me1a_a;
      xky_b   = lut.xky_me1a_b;
      xky_min = xky_t'(`ME1A_XKY_MIN);
      xky_max = xky_t'(`ME1A_XKY_MAX);
    end else begin
      xky_a   = lut.xky_me1b_a;
      xky_b   = lut.xky_me1b_b;
      xky_min = xky_t'(`ME1B_XKY_MIN);
      xky_max = xky_t'(`ME1B_XKY_MAX);
    end
  end

  // odd chambers deliver the pairs swapped
  assign xky_lo  = (xky_a < xky_b) ? xky_a : xky_b;
  assign xky_hi  = (xky_a < xky_b) ? xky_b : xky_a;
  assign wire_lo = (lut.wire_a < lut.wire_b) ? lut.wire_a : lut.wire_b;
  assign wire_hi = (lut.wire_a < lut.wire_b) ? lut.wire_b : lut.wire_a;

  // key window, clamped to the station range
  assign xky_lo_win = (xky_lo > xky_min + delta_xky) ? xky_lo - delta_xky : xky_min;
  assign xky_hi_sum = {1'b0, xky_hi} + {1'b0, delta_xky};
  assign xky_hi_win = (xky_hi_sum > {1'b0, xky_max}) ? xky_max : xky_hi_sum[`XKY_BITS-1:0];

  // wiregroup window, clamped to the chamber
  assign wire_lo_win = (wire_lo > delta_wire) ? wire_lo - delta_wire : '0;
  assign wire_hi_sum = {1'b0, wire_hi} + {1'b0, delta_wire};
  assign wire_hi_win = (wire_hi_sum > (`WIRE_BITS+1)'(`MAX_WIRE)) ?
                       wire_t'(`MAX_WIRE) : wire_hi_sum[`WIRE_BITS-1:0];

  // middles round up when either edge is odd
  assign xky_mid   = (xky_lo >> 1) + (xky_hi >> 1) + xky_t'(xky_lo[0] | xky_hi[0]);
  assign wire_mid  = (wire_lo >> 1) + (wire_hi >> 1) + wire_t'(wire_lo[0] | wire_hi[0]);
  // strip window width for the matching
  assign xky_width = (xky_hi >> 1) - (xky_lo >> 1) + delta_xky;

  // output register
  always_ff @(posedge logic_clock or negedge arst_n) begin
    if (!arst_n) begin
      csc_wire_lo  <= '0;
      csc_wire_hi  <= '0;
      csc_wire_mid <= '0;
      csc_xky_lo   <= '0;
      csc_xky_hi   <= '0;
      csc_xky_mid  <= '0;
      csc_xky_win  <= '0;
      csc_station  <= station_me1b;
      csc_cluster  <= '0;
      csc_valid    <= 1'b0;
    end else begin
      csc_wire_lo  <= wire_lo_win;
      csc_wire_hi  <= wire_hi_win;
      csc_wire_mid <= wire_mid;
      csc_xky_lo   <= xky_lo_win;
      csc_xky_hi   <= xky_hi_win;
      csc_xky_mid  <= xky_mid;
      csc_xky_win  <= xky_width;
      csc_station  <= lut.station;
      csc_cluster  <= lut.cluster;
      csc_valid    <= lut.valid;
    end
  end

endmodule

//--- design/cluster_lut_stage.sv
//**************************************************************************
// lookup stage: pad edges, registered table reads for both parities,
// me1a / me1b decision and station-gated valid
//**************************************************************************
`timescale 1ns/100ps
`include "gem_csc_macros.svh"

module cluster_lut_stage
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
(
  input  logic          logic_clock,
  input  logic          arst_n,
  input  logic          even_chamber,
  input  logic          me1a_enable,
  input  logic          me1b_enable,
  input  cluster_word_t cluster,
  input  logic          cluster_valid,
  input  roll_t         cluster_roll,
  input  pad_t          cluster_pad,
  input  size_t         cluster_size,
  lut_stage_if.lookup   lut
);

  localparam int PAD_ENTRIES  = 1 << `PAD_BITS;
  localparam int ROLL_ENTRIES = 1 << `ROLL_BITS;

  // even chamber in the lower half, odd in the upper half
  xky_t  me1a_tbl   [2*PAD_ENTRIES];
  xky_t  me1b_tbl   [2*PAD_ENTRIES];
  wire_t wire_a_tbl [2*ROLL_ENTRIES];
  wire_t wire_b_tbl [2*ROLL_ENTRIES];

  pad_t                pad_lo;
  pad_t                pad_hi;
  logic [`PAD_BITS:0]  xky_adr_lo;
  logic [`PAD_BITS:0]  xky_adr_hi;
  logic [`ROLL_BITS:0] wire_adr;
  logic                me1a_hit;

  // key tables, fixed at elaboration
  for (genvar i = 0; i < 2*PAD_ENTRIES; i++) begin : g_xky_tbl
    assign me1a_tbl[i] = xky_table_f(station_me1a, i >= PAD_ENTRIES, i % PAD_ENTRIES);
    assign me1b_tbl[i] = xky_table_f(station_me1b, i >= PAD_ENTRIES, i % PAD_ENTRIES);
  end

  // wiregroup tables, one entry per roll and parity
  for (genvar i = 0; i < 2*ROLL_ENTRIES; i++) begin : g_wire_tbl
    assign wire_a_tbl[i] = wire_table_f(i >= ROLL_ENTRIES, 1'b0, i % ROLL_ENTRIES);
    assign wire_b_tbl[i] = wire_table_f(i >= ROLL_ENTRIES, 1'b1, i % ROLL_ENTRIES);
  end

  // pad edges, parked at zero when idle
  always_comb begin
    pad_lo = cluster_valid ? cluster_pad : '0;
    pad_hi = cluster_valid ? pad_t'(cluster_pad + cluster_size) : '0;
  end

  // parity bit selects the table half
  assign xky_adr_lo = {~even_chamber, pad_lo};
  assign xky_adr_hi = {~even_chamber, pad_hi};
  assign wire_adr   = {~even_chamber, cluster_roll};

  // top roll goes to me1a only when enabled
  assign me1a_hit = me1a_enable && (cluster_roll == roll_t'(`ME1A_ROLL));

  // control flags
  always_ff @(posedge logic_clock or negedge arst_n) begin
    if (!arst_n) begin
      lut.valid   <= 1'b0;
      lut.station <= station_me1b;
    end else begin
      lut.valid   <= cluster_valid && (me1b_enable || me1a_hit);
      lut.station <= me1a_hit ? station_me1a : station_me1b;
    end
  end

  // table reads, same edge as the flags
  always_ff @(posedge logic_clock) begin
    lut.cluster    <= cluster;
    lut.wire_a     <= wire_a_tbl[wire_adr];
    lut.wire_b     <= wire_b_tbl[wire_adr];
    lut.xky_me1a_a <= me1a_tbl[xky_adr_lo];
    lut.xky_me1a_b <= me1a_tbl[xky_adr_hi];
    lut.xky_me1b_a <= me1b_tbl[xky_adr_lo];
    lut.xky_me1b_b <= me1b_tbl[xky_adr_hi];
  end

endmodule

//--- design/lut_stage_if.sv
//**************************************************************************
// looked-up ranges passed from the lookup stage to the window stage
//**************************************************************************
`timescale 1ns/100ps

interface lut_stage_if
  import gem_cluster_pkg::*;
  import csc_coord_pkg::*;
();

  // flags
  logic          valid;
  csc_station_e  station;
  cluster_word_t cluster;

  // unordered pairs, a from the low pad edge or table a
  wire_t wire_a;
  wire_t wire_b;
  xky_t  xky_me1a_a;
  xky_t  xky_me1a_b;
  xky_t  xky_me1b_a;
  xky_t  xky_me1b_b;

  modport lookup (
    output valid, station, cluster,
    output wire_a, wire_b, xky_me1a_a, xky_me1a_b, xky_me1b_a, xky_me1b_b
  );

  modport window (
    input valid, station, cluster,
    input wire_a, wire_b, xky_me1a_a, xky_me1a_b, xky_me1b_a, xky_me1b_b
  );

endinterface

//--- design/csc_coord_pkg.sv
//**************************************************************************
// csc side types: wiregroup, eighth-strip key and station enum
// functions building the gem to csc lookup tables
//**************************************************************************
`include "gem_csc_macros.svh"

package csc_coord_pkg;

  typedef logic [`WIRE_BITS-1:0] wire_t;
  typedef logic [`XKY_BITS-1:0]  xky_t;

  // which part of the me11 chamber the cluster is matched to
  typedef enum logic {
    station_me1b = 1'b0,
    station_me1a = 1'b1
  } csc_station_e;

  // wiregroup edge covered by a roll, six wiregroups per roll
  // entry a is the low edge on even chambers, the high edge on odd ones
  function automatic wire_t wire_table_f(input logic odd, input logic entry_b, input int roll);
    int first;
    int last;
    first = roll * 6;
    last  = roll * 6 + 5;
    // odd chambers see the table swapped
    if (odd ^ entry_b) begin
      return wire_t'(last);
    end
    return wire_t'(first);
  endfunction

  // eighth-strip key of a pad edge
  // strips run the other way on odd chambers
  function automatic xky_t xky_table_f(input csc_station_e station, input logic odd, input int pad);
    int key;
    if (station == station_me1a) begin
      key = odd ? (`ME1A_XKY_MAX - pad) : (`ME1A_XKY_MIN + pad);
    end else begin
      // two keys per pad, top key left unused
      key = odd ? (`ME1B_XKY_MAX - 1 - 2 * pad) : (`ME1B_XKY_MIN + 2 * pad);
    end
    return xky_t'(key);
  endfunction

endpackage

//--- design/gem_cluster_pkg.sv
//**************************************************************************
// gem side types: raw cluster word, pad, roll and cluster size
//**************************************************************************
`include "gem_csc_macros.svh"

package gem_cluster_pkg;

  // raw cluster word as received from the gem link
  typedef logic [`CLUSTER_BITS-1:0] cluster_word_t;

  // pad address inside the partition, 0-191 in use
  typedef logic [`PAD_BITS-1:0] pad_t;

  // eta partition, 0 at the narrow end
  typedef logic [`ROLL_BITS-1:0] roll_t;

  // pads beyond the first one
  // 0 means a single pad cluster
  typedef logic [`SIZE_BITS-1:0] size_t;

endpackage

//--- design/gem_csc_macros.svh
//**************************************************************************
// field widths, chamber limits and pipeline depth shared by the
// gem cluster to csc window translation
//**************************************************************************
`ifndef GEM_CSC_MACROS_SVH
`define GEM_CSC_MACROS_SVH

// csc coordinate widths
`define WIRE_BITS    7
`define XKY_BITS     10

// gem cluster fields
`define PAD_BITS     8
`define ROLL_BITS    3
`define SIZE_BITS    3
`define CLUSTER_BITS 14

// wiregroups counted from 0, 48 in total
`define MAX_WIRE     47

// eighth-strip key ranges, me1a sits above me1b
`define ME1B_XKY_MIN 0
`define ME1B_XKY_MAX 511
`define ME1A_XKY_MIN 512
`define ME1A_XKY_MAX 895

// only the top eta partition can reach me1a
`define ME1A_ROLL    7

// lookup stage plus window stage
`define PIPE_DEPTH   2

`endif
